//--- verification/sa_to_st_testdata.txt
# name, sa_grant N S E W L0, vc_assign N S E W L0 (hex)
# then expected outport_sel N S E W L0 and inport_read N S E W L0 (hex)
tt_n_s 45 00 00 00 00 32 00 00 00 00 132 000 060 040 000 0 5 0 0 0
tt_n_e 4a 00 00 00 00 2c 00 00 00 00 14c 000 060 040 000 0 0 6 0 0
tt_n_w 53 00 00 00 00 38 00 00 00 00 178 000 060 040 000 0 0 0 7 0
tt_n_l0 60 00 00 00 00 23 00 00 00 00 183 000 060 040 000 0 0 0 0 4
tt_s_n 00 46 00 00 00 00 29 00 00 00 020 109 060 040 000 6 0 0 0 0
tt_s_e 00 48 00 00 00 00 3b 00 00 00 020 15b 060 040 000 0 0 4 0 0
tt_s_w 00 51 00 00 00 00 24 00 00 00 020 164 060 040 000 0 0 0 5 0
tt_s_l0 00 63 00 00 00 00 30 00 00 00 020 190 060 040 000 0 0 0 0 7
tt_e_w 00 00 45 00 00 00 00 32 00 00 020 000 172 040 000 0 0 0 5 0
tt_e_l0 00 00 4b 00 00 00 00 28 00 00 020 000 188 040 000 0 0 0 0 7
tt_w_e 00 00 00 44 00 00 00 00 3b 00 020 000 060 15b 000 0 0 4 0 0
tt_w_l0 00 00 00 4a 00 00 00 00 21 00 020 000 060 181 000 0 0 0 0 6
tt_l0_n 00 00 00 00 47 00 00 00 00 2c 020 000 060 040 10c 7 0 0 0 0
tt_l0_s 00 00 00 00 48 00 00 00 00 30 020 000 060 040 130 0 4 0 0 0
tt_l0_e 00 00 00 00 52 00 00 00 00 23 020 000 060 040 143 0 0 6 0 0
tt_l0_w 00 00 00 00 61 00 00 00 00 39 020 000 060 040 179 0 0 0 5 0
gate_sa_only 45 00 00 00 00 12 00 00 00 00 032 000 060 040 000 0 0 0 0 0
gate_va_only 00 00 00 00 0b 00 00 00 00 28 020 000 060 040 028 0 0 0 0 0
par_four 49 52 4b 00 44 21 38 32 00 2b 141 178 192 040 10b 4 0 5 6 7
par_all 46 47 48 45 62 28 31 3c 22 2b 128 111 19c 142 16b 7 6 5 6 4
par_mixed 53 49 00 00 00 34 0a 00 00 00 174 04a 060 040 000 0 0 0 7 0
stream_a 00 00 00 4b 00 00 00 00 28 00 020 000 060 188 000 0 0 0 0 7
stream_b 00 00 46 00 00 00 00 21 00 00 020 000 161 040 000 0 0 0 6 0
stream_c 49 52 4b 00 44 21 38 32 00 2b 141 178 192 040 10b 4 0 5 6 7
stream_d 00 00 00 4b 00 00 00 00 28 00 020 000 060 188 000 0 0 0 0 7

//--- src.f
+incdir+design
design/noc_pkg.sv
design/sa_inport_decode.sv
design/outport_grant.sv
design/inport_read_gather.sv
design/sa_to_st.sv
verification/sa_to_st_checker.sv
verification/sa_to_st_tb.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = sa_to_st_tb
FILELIST   = src.f
BUILD_DIR  = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/sa_to_st_tb.sv
// ----------------------------------------
// run from project root, reads testdata file
// ----------------------------------------
`include "noc_settings.svh"

module sa_to_st_tb
  import noc_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam string DATA_FILE = "verification/sa_to_st_testdata.txt";

  typedef sa_grant_t    [`NOC_PORT_NUM-1:0] grant_arr_t;
  typedef vc_assign_t   [`NOC_PORT_NUM-1:0] assign_arr_t;
  typedef outport_sel_t [`NOC_PORT_NUM-1:0] sel_arr_t;
  typedef inport_read_t [`NOC_PORT_NUM-1:0] read_arr_t;

  // first legal input of each output, chosen when nothing is granted
  localparam io_port_t IDLE_INPORT [`NOC_PORT_NUM] = '{S, N, W, E, N};

  logic        clk_i;
  logic        rst_n_i;
  grant_arr_t  sa_grant_i;
  assign_arr_t vc_assign_i;
  sel_arr_t    outport_sel_o;
  read_arr_t   inport_read_o;

  string       name_q[$];
  grant_arr_t  grant_q[$];
  assign_arr_t assign_q[$];
  sel_arr_t    exp_sel_q[$];
  read_arr_t   exp_read_q[$];

  int          err_cnt;
  int          check_cnt;
  int          vec_cnt;
  logic        loaded;
  integer      seed;

  // expectation of the vector currently in flight
  logic        have_pending;
  string       pend_name;
  sel_arr_t    pend_sel;
  read_arr_t   pend_read;

  sa_to_st u_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sa_grant_i    (sa_grant_i),
    .vc_assign_i   (vc_assign_i),
    .outport_sel_o (outport_sel_o),
    .inport_read_o (inport_read_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_outport(string name, int port, outport_sel_t exp_v, outport_sel_t act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("[ERROR] %s outport_sel[%0d] expected %h actual %h", name, port, exp_v, act_v);
    end
  endtask

  task automatic check_inport_read(string name, int port, inport_read_t exp_v,
                                   inport_read_t act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("[ERROR] %s inport_read[%0d] expected %h actual %h", name, port, exp_v, act_v);
    end
  endtask

  task automatic compare_outputs(string name, sel_arr_t exp_sel, read_arr_t exp_read);
    for (int p = 0; p < `NOC_PORT_NUM; p++) begin
      check_outport(name, p, exp_sel[p], outport_sel_o[p]);
      check_inport_read(name, p, exp_read[p], inport_read_o[p]);
    end
  endtask

  function automatic sel_arr_t idle_sel();
    sel_arr_t s;
    s = '0;
    for (int p = 0; p < `NOC_PORT_NUM; p++) begin
      s[p].inport = IDLE_INPORT[p];
    end
    return s;
  endfunction

  // vector groups share the name part before the first underscore
  function automatic string group_of(string name);
    for (int i = 0; i < name.len(); i++) begin
      if (name[i] == "_") begin
        return name.substr(0, i - 1);
      end
    end
    return name;
  endfunction

  // drive on the falling edge, check what was driven one cycle before
  task automatic apply_vector(string name, grant_arr_t sg, assign_arr_t va,
                              sel_arr_t exp_sel, read_arr_t exp_read);
    @(negedge clk_i);
    if (have_pending) begin
      compare_outputs(pend_name, pend_sel, pend_read);
    end
    sa_grant_i   = sg;
    vc_assign_i  = va;
    pend_name    = name;
    pend_sel     = exp_sel;
    pend_read    = exp_read;
    have_pending = 1'b1;
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    int          n;
    string       line;
    string       name;
    logic [15:0] f [20];
    grant_arr_t  sg;
    assign_arr_t va;
    sel_arr_t    eo;
    read_arr_t   er;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open stimulus file %s", DATA_FILE);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0) begin
          break;
        end
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
        if (n <= 0) begin
          continue;
        end
        if (n != 21) begin
          err_cnt++;
          $display("stimulus line could not be parsed: %s", line);
          continue;
        end
        for (int p = 0; p < `NOC_PORT_NUM; p++) begin
          sg[p] = sa_grant_t'(f[p][6:0]);
          va[p] = vc_assign_t'(f[5+p][5:0]);
          eo[p] = outport_sel_t'(f[10+p][8:0]);
          er[p] = inport_read_t'(f[15+p][2:0]);
        end
        name_q.push_back(name);
        grant_q.push_back(sg);
        assign_q.push_back(va);
        exp_sel_q.push_back(eo);
        exp_read_q.push_back(er);
      end
      $fclose(fd);
    end
  endtask

  // bound by vector count, with room for idle gaps and reset
  initial begin
    wait (loaded);
    #((vec_cnt * 4 + 20) * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  initial begin
    int unsigned idle_n;
    rst_n_i      = 1'b0;
    sa_grant_i   = '0;
    vc_assign_i  = '0;
    err_cnt      = 0;
    check_cnt    = 0;
    have_pending = 1'b0;
    loaded       = 1'b0;
    seed         = 32'hf60a_f29d;
    load_vectors();
    vec_cnt = name_q.size();
    loaded  = 1'b1;
    if (vec_cnt == 0) begin
      err_cnt++;
      $display("stimulus file holds no vectors");
    end

    repeat (3) @(negedge clk_i);
    compare_outputs("reset", '0, '0);
    rst_n_i      = 1'b1;
    pend_name    = "reset_idle";
    pend_sel     = idle_sel();
    pend_read    = '0;
    have_pending = 1'b1;

    for (int v = 0; v < vec_cnt; v++) begin
      if (v > 0 && group_of(name_q[v]) != group_of(name_q[v-1])) begin
        idle_n = 1 + ($unsigned($random(seed)) % 3);
        repeat (idle_n) begin
          apply_vector("idle", '0, '0, idle_sel(), '0);
        end
      end
      apply_vector(name_q[v], grant_q[v], assign_q[v], exp_sel_q[v], exp_read_q[v]);
    end
    apply_vector("flush", '0, '0, idle_sel(), '0);
    @(negedge clk_i);
    compare_outputs(pend_name, pend_sel, pend_read);

    $display("vectors: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             vec_cnt, check_cnt, err_cnt, u_dut.u_checker.assert_fail_cnt);
    if (err_cnt == 0 && u_dut.u_checker.assert_fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verification/sa_to_st_checker.sv
// ----------------------------------------
// bound to sa_to_st, assumes allocator rules
// ----------------------------------------
`include "noc_settings.svh"

module sa_to_st_checker
  import noc_pkg::*;
(
  input logic                             clk_i,
  input logic                             rst_n_i,
  input sa_grant_t    [`NOC_PORT_NUM-1:0] sa_grant_i,
  input outport_sel_t [`NOC_PORT_NUM-1:0] outport_sel_o,
  input inport_read_t [`NOC_PORT_NUM-1:0] inport_read_o
);

  logic any_active;
  logic double_grant;
  int   assert_fail_cnt = 0;

  always_comb begin
    any_active = 1'b0;
    for (int p = 0; p < `NOC_PORT_NUM; p++) begin
      any_active = any_active | outport_sel_o[p].vld | inport_read_o[p].en;
    end
  end

  // two traversing outputs reading the same input
  always_comb begin
    double_grant = 1'b0;
    for (int a = 0; a < `NOC_PORT_NUM; a++) begin
      for (int b = a + 1; b < `NOC_PORT_NUM; b++) begin
        if (outport_sel_o[a].vld && outport_sel_o[b].vld &&
            (outport_sel_o[a].inport == outport_sel_o[b].inport)) begin
          double_grant = 1'b1;
        end
      end
    end
  end

  for (genvar g = 0; g < `NOC_PORT_NUM; g++) begin : gen_onehot
    onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(sa_grant_i[g].inport_oh))
      else begin
        assert_fail_cnt++;
        $error("sa_grant index of output %0d has more than one bit set", g);
      end
  end

  no_double_grant_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !double_grant)
    else begin
      assert_fail_cnt++;
      $error("one input port granted by two outputs in the same cycle");
    end

  // outputs of the first cycle after release stay idle
  reset_quiet_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |=> !any_active)
    else begin
      assert_fail_cnt++;
      $error("valid or enable high in first cycle after reset");
    end

endmodule

bind sa_to_st sa_to_st_checker u_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .sa_grant_i    (sa_grant_i),
  .outport_sel_o (outport_sel_o),
  .inport_read_o (inport_read_o)
);

//--- design/sa_to_st.sv
// ----------------------------------------
// outputs follow inputs by one clock
// ----------------------------------------
`include "noc_settings.svh"

module sa_to_st
  import noc_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  sa_grant_t    [`NOC_PORT_NUM-1:0] sa_grant_i,
  input  vc_assign_t   [`NOC_PORT_NUM-1:0] vc_assign_i,
  output outport_sel_t [`NOC_PORT_NUM-1:0] outport_sel_o,
  output inport_read_t [`NOC_PORT_NUM-1:0] inport_read_o
);

  io_port_t   [`NOC_PORT_NUM-1:0] inport_id;
  port_mask_t [`NOC_PORT_NUM-1:0] inport_mask;
  port_mask_t                     granted;

  // one turn table decoder per output port
  for (genvar g = 0; g < `NOC_PORT_NUM; g++) begin : gen_decode
    sa_inport_decode #(
      .OUTPORT (io_port_t'(g))
    ) u_decode (
      .sa_oh_i       (sa_grant_i[g].inport_oh),
      .inport_o      (inport_id[g]),
      .inport_mask_o (inport_mask[g])
    );
  end

  outport_grant u_outport_grant (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sa_grant_i    (sa_grant_i),
    .vc_assign_i   (vc_assign_i),
    .inport_i      (inport_id),
    .granted_o     (granted),
    .outport_sel_o (outport_sel_o)
  );

  // reads are gated by the combined grant, not vc assignment alone
  inport_read_gather u_inport_read_gather (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .inport_mask_i (inport_mask),
    .granted_i     (granted),
    .sa_grant_i    (sa_grant_i),
    .inport_read_o (inport_read_o)
  );

endmodule

//--- design/inport_read_gather.sv
// ----------------------------------------
// assumes each input granted by one output
// ----------------------------------------
`include "noc_settings.svh"

module inport_read_gather
  import noc_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  port_mask_t   [`NOC_PORT_NUM-1:0] inport_mask_i,
  input  port_mask_t                       granted_i,
  input  sa_grant_t    [`NOC_PORT_NUM-1:0] sa_grant_i,
  output inport_read_t [`NOC_PORT_NUM-1:0] inport_read_o
);

  // rows indexed by input, columns by output
  port_mask_t   [`NOC_PORT_NUM-1:0] hit;
  inport_read_t [`NOC_PORT_NUM-1:0] rd_d;
  inport_read_t [`NOC_PORT_NUM-1:0] rd_q;

  // transpose, keeping only outputs that really traverse
  always_comb begin
    for (int i = 0; i < `NOC_PORT_NUM; i++) begin
      for (int o = 0; o < `NOC_PORT_NUM; o++) begin
        hit[i][o] = inport_mask_i[o][i] & granted_i[o];
      end
    end
  end

  // or-reduce, only the granting output contributes a vc id
  always_comb begin
    for (int i = 0; i < `NOC_PORT_NUM; i++) begin
      rd_d[i].en    = |hit[i];
      rd_d[i].vc_id = '0;
      for (int o = 0; o < `NOC_PORT_NUM; o++) begin
        rd_d[i].vc_id = rd_d[i].vc_id | ({`NOC_VC_ID_W{hit[i][o]}} & sa_grant_i[o].vc_id);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_q <= '0;
    end else begin
      rd_q <= rd_d;
    end
  end

  assign inport_read_o = rd_q;

endmodule

//--- design/outport_grant.sv
// ----------------------------------------
// one cycle latency, no back-pressure
// ----------------------------------------
`include "noc_settings.svh"

module outport_grant
  import noc_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  sa_grant_t    [`NOC_PORT_NUM-1:0] sa_grant_i,
  input  vc_assign_t   [`NOC_PORT_NUM-1:0] vc_assign_i,
  input  io_port_t     [`NOC_PORT_NUM-1:0] inport_i,
  output port_mask_t                       granted_o,
  output outport_sel_t [`NOC_PORT_NUM-1:0] outport_sel_o
);

  port_mask_t                       granted;
  outport_sel_t [`NOC_PORT_NUM-1:0] sel_d;
  outport_sel_t [`NOC_PORT_NUM-1:0] sel_q;

  // a traversal needs both the switch and a downstream vc
  always_comb begin
    for (int o = 0; o < `NOC_PORT_NUM; o++) begin
      granted[o] = sa_grant_i[o].vld & vc_assign_i[o].vld;
    end
  end

  // data fields pass through even when the output is idle
  always_comb begin
    for (int o = 0; o < `NOC_PORT_NUM; o++) begin
      sel_d[o].vld        = granted[o];
      sel_d[o].inport     = inport_i[o];
      sel_d[o].vc_id      = vc_assign_i[o].vc_id;
      sel_d[o].look_ahead = vc_assign_i[o].look_ahead;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_d;
    end
  end

  // combined grant goes to the read gather before the register
  assign granted_o     = granted;
  assign outport_sel_o = sel_q;

endmodule

//--- design/sa_inport_decode.sv
// ----------------------------------------
// expects at most one bit set in sa_oh_i
// ----------------------------------------
`include "noc_settings.svh"

module sa_inport_decode
  import noc_pkg::*;
#(
  parameter io_port_t OUTPORT = N
) (
  input  sa_onehot_t sa_oh_i,
  output io_port_t   inport_o,
  output port_mask_t inport_mask_o
);

  // dimension order turn rules, one row per output port
  // E and W rows only use the first two entries
  localparam io_port_t TURN_TBL [`NOC_PORT_NUM][`NOC_SA_IN_MAX] = '{
    '{S, E,  W, L0},
    '{N, E,  W, L0},
    '{W, L0, W, L0},
    '{E, L0, E, L0},
    '{N, S,  E, W }
  };

  // legal inputs per output
  localparam int FAN_IN_TBL [`NOC_PORT_NUM] = '{4, 4, 2, 2, 4};

  localparam int FAN_IN = FAN_IN_TBL[OUTPORT];

  io_port_t   inport;
  port_mask_t inport_mask;

  // walk only the legal part of the index, extra bits are don't care
  always_comb begin
    inport      = TURN_TBL[OUTPORT][0];
    inport_mask = '0;
    for (int i = 0; i < FAN_IN; i++) begin
      if (sa_oh_i[i]) begin
        inport                               = TURN_TBL[OUTPORT][i];
        inport_mask                          = '0;
        inport_mask[TURN_TBL[OUTPORT][i]]    = 1'b1;
      end
    end
  end

  assign inport_o      = inport;
  assign inport_mask_o = inport_mask;

endmodule

//--- design/noc_pkg.sv
// ----------------------------------------
// port ids are fixed, L0 is the only local
// ----------------------------------------
`include "noc_settings.svh"

package noc_pkg;

  // router port ids, also used as look-ahead route
  typedef enum logic [2:0] {
    N  = 3'd0,
    S  = 3'd1,
    E  = 3'd2,
    W  = 3'd3,
    L0 = 3'd4
  } io_port_t;

  typedef logic [`NOC_VC_ID_W-1:0]   vc_id_t;
  typedef logic [`NOC_SA_IN_MAX-1:0] sa_onehot_t;
  typedef logic [`NOC_PORT_NUM-1:0]  port_mask_t;

  // global switch allocation result for one output
  typedef struct packed {
    logic       vld;
    sa_onehot_t inport_oh;
    vc_id_t     vc_id;
  } sa_grant_t;

  // vc allocation result for one output
  typedef struct packed {
    logic     vld;
    vc_id_t   vc_id;
    io_port_t look_ahead;
  } vc_assign_t;

  // crossbar selection, also read by the credit counter
  typedef struct packed {
    logic     vld;
    io_port_t inport;
    vc_id_t   vc_id;
    io_port_t look_ahead;
  } outport_sel_t;

  // buffer read request for one input
  typedef struct packed {
    logic   en;
    vc_id_t vc_id;
  } inport_read_t;

endpackage

//--- design/noc_settings.svh
// ----------------------------------------
// single local port router, 5 ports total
// ----------------------------------------
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// router ports, N S E W plus one local
`define NOC_PORT_NUM 5

// virtual channel id width
`define NOC_VC_ID_W 2

// widest switch allocator one-hot index
// N, S and L0 outputs take 4 inputs, E and W take 2
`define NOC_SA_IN_MAX 4

`endif
